// File: common/rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// datapath width in bits
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: common/rv32i_isa_pkg.sv
`include "rv32i_settings.svh"

package rv32i_isa_pkg;

  typedef logic [`RV_XLEN-1:0] rv32i_word;
  typedef logic [$clog2(`RV_REG_COUNT)-1:0] rv32i_reg;
  typedef logic [3:0] byte_mask;  // one enable per byte lane

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode_e;

  // funct3 of the integer ops
  typedef enum logic [2:0] {
    f3_add  = 3'b000,  // add or sub
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,  // srl or sra, picked by instr[30]
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } arith_funct3_e;

  // funct3 of loads and stores, word only
  typedef enum logic [2:0] {
    mem_word = 3'b010
  } mem_width_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;
  import rv32i_isa_pkg::*;

  // source of the value written back
  typedef enum logic [1:0] {wb_alu, wb_imm, wb_load} wb_sel_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wrb} fwd_sel_e;

  typedef struct packed {
    logic      valid;
    rv32i_word pc;
    rv32i_word instr;
  } fetch_word_t;

  typedef struct packed {
    logic          valid;
    rv32i_opcode_e opcode;
    rv32i_reg      rs1;
    rv32i_reg      rs2;
    rv32i_reg      rd;
    logic          has_rd;
    alu_op_e       alu_op;
    logic          use_imm;  // second alu operand is imm
    rv32i_word     imm;
    logic          mem_read;
    logic          mem_write;
    wb_sel_e       wb_sel;
    rv32i_word     rs1_data;
    rv32i_word     rs2_data;
  } exe_ctrl_t;

  typedef struct packed {
    logic      valid;
    rv32i_reg  rd;
    logic      has_rd;
    logic      mem_read;
    logic      mem_write;
    wb_sel_e   wb_sel;
    rv32i_word alu_out;  // also the data address
    rv32i_word imm;
    rv32i_word store_data;
  } mem_ctrl_t;

  typedef struct packed {
    logic      valid;
    rv32i_reg  rd;
    logic      has_rd;
    rv32i_word result;
  } wrb_ctrl_t;

endpackage

// File: source/fetch_stage.sv
`include "rv32i_settings.svh"

module fetch_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     freeze,
  input  logic                     load_stall,
  input  rv32i_isa_pkg::rv32i_word instr_mem_rdata,
  output logic                     instr_read,
  output rv32i_isa_pkg::rv32i_word instr_mem_address,
  output pipe_pkg::fetch_word_t    fetch_word
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  rv32i_word pc;
  logic      hold;  // pc and fetch register keep their value

  assign hold = freeze || load_stall;
  assign instr_mem_address = pc;  // request address straight from pc

  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= `RV_RESET_PC;
      instr_read <= 1'b0;
    end else begin
      instr_read <= 1'b1;  // always fetching once out of reset
      if (!hold && instr_read) pc <= pc + 4;
    end
  end

  // instruction lands here with the pc it came from
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_word.valid <= 1'b0;
      fetch_word.instr <= `RV_NOP;
    end else if (!hold) begin
      fetch_word.valid <= instr_read;  // nothing fetched yet in first cycle
      fetch_word.instr <= instr_mem_rdata;
    end
    if (!hold) fetch_word.pc <= pc;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    instr_read |-> (instr_mem_address[1:0] == 2'b00));

endmodule

// File: decode/instr_decoder.sv
module instr_decoder (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     freeze,
  input  logic                     load_stall,
  input  pipe_pkg::fetch_word_t    fetch_word,
  input  rv32i_isa_pkg::rv32i_word rs1_data,
  input  rv32i_isa_pkg::rv32i_word rs2_data,
  output pipe_pkg::exe_ctrl_t      exe_ctrl
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  rv32i_word     instr;
  rv32i_opcode_e opcode;
  arith_funct3_e funct3;
  logic          alt;  // funct7 bit 5
  exe_ctrl_t     dec;

  assign instr  = fetch_word.instr;
  assign opcode = rv32i_opcode_e'(instr[6:0]);
  assign funct3 = arith_funct3_e'(instr[14:12]);
  assign alt    = instr[30];

  function automatic alu_op_e alu_fn(arith_funct3_e f3, logic sub, logic arith);
    case (f3)
      f3_add:  alu_fn = sub ? alu_sub : alu_add;
      f3_sll:  alu_fn = alu_sll;
      f3_slt:  alu_fn = alu_slt;
      f3_sltu: alu_fn = alu_sltu;
      f3_xor:  alu_fn = alu_xor;
      f3_sr:   alu_fn = arith ? alu_sra : alu_srl;
      f3_or:   alu_fn = alu_or;
      default: alu_fn = alu_and;
    endcase
  endfunction

  always_comb begin
    dec          = '0;
    dec.valid    = fetch_word.valid;
    dec.opcode   = opcode;
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.rd       = instr[11:7];
    dec.alu_op   = alu_add;  // address add for loads and stores
    dec.imm      = rv32i_word'(signed'(instr[31:20]));  // I type
    dec.wb_sel   = wb_alu;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    case (opcode)
      op_imm: begin
        dec.has_rd  = 1'b1;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_fn(funct3, 1'b0, alt);  // no subi
      end
      op_reg: begin
        dec.has_rd = 1'b1;
        dec.alu_op = alu_fn(funct3, alt, alt);
      end
      op_lui: begin
        dec.has_rd = 1'b1;
        dec.imm    = {instr[31:12], 12'b0};  // U type
        dec.wb_sel = wb_imm;
      end
      op_load: begin
        dec.valid    = fetch_word.valid && (instr[14:12] == mem_word);
        dec.has_rd   = 1'b1;
        dec.use_imm  = 1'b1;
        dec.mem_read = 1'b1;
        dec.wb_sel   = wb_load;
      end
      op_store: begin
        dec.valid     = fetch_word.valid && (instr[14:12] == mem_word);
        dec.use_imm   = 1'b1;
        dec.mem_write = 1'b1;
        dec.imm       = rv32i_word'(signed'({instr[31:25], instr[11:7]}));  // S type
      end
      default: dec.valid = 1'b0;  // unsupported, goes down as a bubble
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) exe_ctrl <= '0;
    else if (!freeze && !load_stall) exe_ctrl <= dec;
  end

endmodule

// File: decode/regfile.sv
`include "rv32i_settings.svh"

module regfile (
  input  logic                     clk,
  input  logic                     rst,
  input  rv32i_isa_pkg::rv32i_reg  rs1_addr,
  input  rv32i_isa_pkg::rv32i_reg  rs2_addr,
  input  pipe_pkg::wrb_ctrl_t      wrb_ctrl,
  input  logic                     freeze,
  output rv32i_isa_pkg::rv32i_word rs1_data,
  output rv32i_isa_pkg::rv32i_word rs2_data
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  rv32i_word regs [1:`RV_REG_COUNT-1];  // x0 has no storage
  logic      wr_en;

  assign wr_en = wrb_ctrl.valid && wrb_ctrl.has_rd && (wrb_ctrl.rd != '0) && !freeze;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wrb_ctrl.rd] <= wrb_ctrl.result;
    end
  end

  function automatic rv32i_word read_port(rv32i_reg addr);
    if (addr == '0) read_port = '0;
    else if (wr_en && (wrb_ctrl.rd == addr)) read_port = wrb_ctrl.result;  // write-through
    else read_port = regs[addr];
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

endmodule

// File: execute/hazard_unit.sv
module hazard_unit (
  input  pipe_pkg::exe_ctrl_t exe_ctrl,
  input  pipe_pkg::mem_ctrl_t mem_ctrl,
  input  pipe_pkg::wrb_ctrl_t wrb_ctrl,
  input  logic                instr_mem_resp,
  input  logic                data_mem_resp,
  output logic                freeze,
  output logic                load_stall,
  output pipe_pkg::fwd_sel_e  fwd_rs1,
  output pipe_pkg::fwd_sel_e  fwd_rs2
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic use_rs1;      // execute reads rs1
  logic use_rs2;      // only R type and stores read rs2
  logic mem_writes;   // memory stage will write a register other than x0
  logic wrb_writes;
  logic data_access;

  assign use_rs1 = exe_ctrl.valid && (exe_ctrl.opcode != op_lui);
  assign use_rs2 = exe_ctrl.valid &&
                   ((exe_ctrl.opcode == op_reg) || (exe_ctrl.opcode == op_store));
  assign mem_writes = mem_ctrl.valid && mem_ctrl.has_rd && (mem_ctrl.rd != '0);
  assign wrb_writes = wrb_ctrl.valid && wrb_ctrl.has_rd && (wrb_ctrl.rd != '0);

  function automatic fwd_sel_e pick_src(rv32i_reg src, logic used, rv32i_reg mem_rd,
                                        logic mem_ok, rv32i_reg wrb_rd, logic wrb_ok);
    if (!used) pick_src = fwd_none;
    else if (mem_ok && (mem_rd == src)) pick_src = fwd_mem;  // youngest value first
    else if (wrb_ok && (wrb_rd == src)) pick_src = fwd_wrb;
    else pick_src = fwd_none;
  endfunction

  assign fwd_rs1 = pick_src(exe_ctrl.rs1, use_rs1, mem_ctrl.rd, mem_writes,
                            wrb_ctrl.rd, wrb_writes);
  assign fwd_rs2 = pick_src(exe_ctrl.rs2, use_rs2, mem_ctrl.rd, mem_writes,
                            wrb_ctrl.rd, wrb_writes);

  // load result only exists a cycle later
  assign load_stall = mem_ctrl.valid && mem_ctrl.mem_read && (mem_ctrl.rd != '0) &&
                      ((use_rs1 && (exe_ctrl.rs1 == mem_ctrl.rd)) ||
                       (use_rs2 && (exe_ctrl.rs2 == mem_ctrl.rd)));

  assign data_access = mem_ctrl.valid && (mem_ctrl.mem_read || mem_ctrl.mem_write);
  assign freeze = !instr_mem_resp || (data_access && !data_mem_resp);

  // x0 reads as zero in every stage so a forward of it would corrupt the operand
  always_comb begin
    assert ((exe_ctrl.rs1 != '0 || fwd_rs1 == fwd_none) &&
            (exe_ctrl.rs2 != '0 || fwd_rs2 == fwd_none))
      else $error("forward selected for x0");
  end

endmodule

// File: execute/execute_stage.sv
module execute_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                freeze,
  input  logic                load_stall,
  input  pipe_pkg::exe_ctrl_t exe_ctrl,
  input  pipe_pkg::fwd_sel_e  fwd_rs1,
  input  pipe_pkg::fwd_sel_e  fwd_rs2,
  input  pipe_pkg::wrb_ctrl_t wrb_ctrl,
  output pipe_pkg::mem_ctrl_t mem_ctrl
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  rv32i_word mem_result;  // what the memory stage will write back
  rv32i_word base_a;
  rv32i_word base_b;
  rv32i_word op_a;
  rv32i_word op_b_reg;
  rv32i_word op_b;
  rv32i_word alu_out;
  rv32i_word held_a;      // operands caught during a load-use stall
  rv32i_word held_b;
  logic      stall_q;
  mem_ctrl_t nxt;

  assign mem_result = (mem_ctrl.wb_sel == wb_imm) ? mem_ctrl.imm : mem_ctrl.alu_out;

  // after a stall the older writeback is gone, so use what was caught then
  assign base_a = stall_q ? held_a : exe_ctrl.rs1_data;
  assign base_b = stall_q ? held_b : exe_ctrl.rs2_data;

  function automatic rv32i_word fwd_mux(fwd_sel_e sel, rv32i_word base, rv32i_word mem_v,
                                        rv32i_word wrb_v);
    case (sel)
      fwd_mem: fwd_mux = mem_v;
      fwd_wrb: fwd_mux = wrb_v;
      default: fwd_mux = base;
    endcase
  endfunction

  assign op_a     = fwd_mux(fwd_rs1, base_a, mem_result, wrb_ctrl.result);
  assign op_b_reg = fwd_mux(fwd_rs2, base_b, mem_result, wrb_ctrl.result);
  assign op_b     = exe_ctrl.use_imm ? exe_ctrl.imm : op_b_reg;

  always_comb begin
    case (exe_ctrl.alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_slt:  alu_out = rv32i_word'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_out = rv32i_word'(op_a < op_b);
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = rv32i_word'($signed(op_a) >>> op_b[4:0]);
      alu_or:   alu_out = op_a | op_b;
      default:  alu_out = op_a & op_b;
    endcase
  end

  always_comb begin
    nxt.valid      = exe_ctrl.valid;
    nxt.rd         = exe_ctrl.rd;
    nxt.has_rd     = exe_ctrl.has_rd;
    nxt.mem_read   = exe_ctrl.mem_read;
    nxt.mem_write  = exe_ctrl.mem_write;
    nxt.wb_sel     = exe_ctrl.wb_sel;
    nxt.alu_out    = alu_out;
    nxt.imm        = exe_ctrl.imm;
    nxt.store_data = op_b_reg;  // forwarded rs2
  end

  always_ff @(posedge clk) begin
    if (rst) stall_q <= 1'b0;
    else if (!freeze) stall_q <= load_stall;
  end

  always_ff @(posedge clk) begin
    if (!freeze && load_stall) begin
      held_a <= op_a;
      held_b <= op_b_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) mem_ctrl <= '0;
    else if (!freeze) mem_ctrl <= load_stall ? '0 : nxt;  // bubble behind a stalled load
  end

endmodule

// File: source/memory_stage.sv
module memory_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     freeze,
  input  pipe_pkg::mem_ctrl_t      mem_ctrl,
  input  rv32i_isa_pkg::rv32i_word data_mem_rdata,
  output logic                     data_read,
  output logic                     data_write,
  output rv32i_isa_pkg::byte_mask  data_mbe,
  output rv32i_isa_pkg::rv32i_word data_mem_address,
  output rv32i_isa_pkg::rv32i_word data_mem_wdata,
  output pipe_pkg::wrb_ctrl_t      wrb_ctrl
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic      access;
  rv32i_word result;

  // request held as long as the access sits here
  assign data_read  = mem_ctrl.valid && mem_ctrl.mem_read;
  assign data_write = mem_ctrl.valid && mem_ctrl.mem_write;
  assign access     = data_read || data_write;

  assign data_mem_address = mem_ctrl.alu_out & ~rv32i_word'(3);  // word aligned
  assign data_mbe         = access ? 4'b1111 : 4'b0000;          // lw/sw only
  assign data_mem_wdata   = mem_ctrl.store_data;

  always_comb begin
    case (mem_ctrl.wb_sel)
      wb_imm:  result = mem_ctrl.imm;
      wb_load: result = data_mem_rdata;  // valid whenever freeze is low
      default: result = mem_ctrl.alu_out;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrb_ctrl.valid  <= 1'b0;
      wrb_ctrl.has_rd <= 1'b0;
    end else if (!freeze) begin
      wrb_ctrl.valid  <= mem_ctrl.valid;
      wrb_ctrl.has_rd <= mem_ctrl.has_rd;
    end
    if (!freeze) begin
      wrb_ctrl.rd     <= mem_ctrl.rd;
      wrb_ctrl.result <= result;
    end
  end

  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
    !(data_read && data_write));

  // an unanswered access keeps its address until the pipeline moves
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (access && freeze) |=> $stable(data_mem_address));

endmodule

// File: source/cpu_pipeline.sv
module cpu_pipeline (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instr_mem_resp,
  input  rv32i_isa_pkg::rv32i_word instr_mem_rdata,
  input  logic                     data_mem_resp,
  input  rv32i_isa_pkg::rv32i_word data_mem_rdata,
  output logic                     instr_read,
  output rv32i_isa_pkg::rv32i_word instr_mem_address,
  output logic                     data_read,
  output logic                     data_write,
  output rv32i_isa_pkg::byte_mask  data_mbe,
  output rv32i_isa_pkg::rv32i_word data_mem_address,
  output rv32i_isa_pkg::rv32i_word data_mem_wdata
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  fetch_word_t fetch_word;
  exe_ctrl_t   exe_ctrl;
  mem_ctrl_t   mem_ctrl;
  wrb_ctrl_t   wrb_ctrl;
  rv32i_word   rs1_data;
  rv32i_word   rs2_data;
  logic        freeze;
  logic        load_stall;
  fwd_sel_e    fwd_rs1;
  fwd_sel_e    fwd_rs2;

  fetch_stage u_fetch (
    .clk(clk), .rst(rst), .freeze(freeze), .load_stall(load_stall),
    .instr_mem_rdata(instr_mem_rdata), .instr_read(instr_read),
    .instr_mem_address(instr_mem_address), .fetch_word(fetch_word)
  );

  instr_decoder u_decode (
    .clk(clk), .rst(rst), .freeze(freeze), .load_stall(load_stall), .fetch_word(fetch_word),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .exe_ctrl(exe_ctrl)
  );

  // source fields read straight from the fetched word
  regfile u_regfile (
    .clk(clk), .rst(rst), .rs1_addr(fetch_word.instr[19:15]),
    .rs2_addr(fetch_word.instr[24:20]), .wrb_ctrl(wrb_ctrl), .freeze(freeze),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  hazard_unit u_hazard (
    .exe_ctrl(exe_ctrl), .mem_ctrl(mem_ctrl), .wrb_ctrl(wrb_ctrl),
    .instr_mem_resp(instr_mem_resp), .data_mem_resp(data_mem_resp), .freeze(freeze),
    .load_stall(load_stall), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
  );

  execute_stage u_execute (
    .clk(clk), .rst(rst), .freeze(freeze), .load_stall(load_stall), .exe_ctrl(exe_ctrl),
    .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .wrb_ctrl(wrb_ctrl), .mem_ctrl(mem_ctrl)
  );

  memory_stage u_memory (
    .clk(clk), .rst(rst), .freeze(freeze), .mem_ctrl(mem_ctrl),
    .data_mem_rdata(data_mem_rdata), .data_read(data_read), .data_write(data_write),
    .data_mbe(data_mbe), .data_mem_address(data_mem_address),
    .data_mem_wdata(data_mem_wdata), .wrb_ctrl(wrb_ctrl)
  );

endmodule

// File: dv/tb_cpu_pipeline.sv
`include "rv32i_settings.svh"

module tb_cpu_pipeline;
  import rv32i_isa_pkg::*;

  localparam int DRIVE_DELAY   = 1;    // input skew after the rising edge
  localparam int RESET_CYCLES  = 16;
  localparam int STORE_TIMEOUT = 400;  // cycles allowed per store
  localparam int DRAIN_CYCLES  = 20;

  typedef struct packed {
    rv32i_word addr;
    rv32i_word data;
    byte_mask  mask;
  } store_t;

  logic      clk;
  logic      rst;
  logic      instr_mem_resp;
  rv32i_word instr_mem_rdata;
  logic      data_mem_resp;
  rv32i_word data_mem_rdata;
  logic      instr_read;
  rv32i_word instr_mem_address;
  logic      data_read;
  logic      data_write;
  byte_mask  data_mbe;
  rv32i_word data_mem_address;
  rv32i_word data_mem_wdata;

  rv32i_word   prog [$];           // words from the reset pc upward
  store_t      expected [$];
  store_t      seen [$];           // stores retired by the DUT, oldest first
  rv32i_word   dmem [rv32i_word];  // sparse, word addressed by byte address
  logic [31:0] rnd;
  int          cycle_count;
  rv32i_word   last_fetch;
  logic        fetch_started;

  cpu_pipeline UUT (
    .clk(clk), .rst(rst), .instr_mem_resp(instr_mem_resp),
    .instr_mem_rdata(instr_mem_rdata), .data_mem_resp(data_mem_resp),
    .data_mem_rdata(data_mem_rdata), .instr_read(instr_read),
    .instr_mem_address(instr_mem_address), .data_read(data_read),
    .data_write(data_write), .data_mbe(data_mbe), .data_mem_address(data_mem_address),
    .data_mem_wdata(data_mem_wdata)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // value of untouched memory spread over every address bit
  function automatic rv32i_word fill_word(rv32i_word a);
    return ~a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic rv32i_word instr_at(rv32i_word addr);
    rv32i_word idx;
    idx = (addr - `RV_RESET_PC) >> 2;
    if (addr < `RV_RESET_PC || idx >= prog.size()) return `RV_NOP;  // past program end
    return prog[idx];
  endfunction

  function automatic rv32i_word data_at(rv32i_word addr);
    if (dmem.exists(addr)) return dmem[addr];
    return fill_word(addr);
  endfunction

  // RV32I encodings
  function automatic rv32i_word itype_word(rv32i_opcode_e opc, logic [2:0] f3, int rd, int rs1,
                                           int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic rv32i_word rtype_word(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                           int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
  endfunction

  function automatic rv32i_word stype_word(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};  // sw
  endfunction

  function automatic rv32i_word utype_word(int rd, int imm20);
    return {imm20[19:0], rd[4:0], op_lui};
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, rv32i_word got, rv32i_word exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_mask(string name, byte_mask got, byte_mask exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic expect_store(rv32i_word addr, rv32i_word data);
    store_t s;
    s.addr = addr;
    s.data = data;
    s.mask = 4'b1111;  // word stores only
    expected.push_back(s);
  endtask

  task automatic load_program();
    prog.push_back(itype_word(op_imm, f3_add, 1, 0, 5));          // x1 = 5
    prog.push_back(itype_word(op_imm, f3_add, 2, 1, 7));          // x2 = 12 through mem fwd
    prog.push_back(rtype_word(7'h00, f3_add, 3, 1, 2));           // x3 = 17 over both paths
    prog.push_back(rtype_word(7'h20, f3_add, 4, 3, 1));           // x4 = 12 by sub
    prog.push_back(itype_word(op_imm, f3_add, 10, 0, 256));       // data base 0x100
    prog.push_back(stype_word(3, 10, 0));
    prog.push_back(stype_word(4, 10, 4));
    prog.push_back(itype_word(op_imm, f3_sll, 5, 1, 4));          // x5 = 80
    prog.push_back(itype_word(op_imm, f3_xor, 6, 5, -1));         // x6 = ~80
    prog.push_back(itype_word(op_imm, f3_sr, 7, 6, 32'h402));     // srai 2
    prog.push_back(itype_word(op_imm, f3_sr, 8, 6, 28));          // srli 28
    prog.push_back(rtype_word(7'h00, f3_slt, 9, 6, 1));
    prog.push_back(rtype_word(7'h00, f3_sltu, 11, 6, 1));
    prog.push_back(rtype_word(7'h00, f3_or, 12, 7, 8));
    prog.push_back(rtype_word(7'h00, f3_and, 13, 12, 5));
    prog.push_back(rtype_word(7'h00, f3_xor, 14, 13, 9));
    prog.push_back(stype_word(7, 10, 8));
    prog.push_back(stype_word(8, 10, 12));
    prog.push_back(stype_word(9, 10, 16));
    prog.push_back(stype_word(11, 10, 20));
    prog.push_back(stype_word(14, 10, 24));
    prog.push_back(utype_word(15, 20'h12345));
    prog.push_back(stype_word(15, 10, 28));                       // lui value forwarded
    prog.push_back(itype_word(op_imm, f3_add, 0, 1, 99));         // write to x0 dropped
    prog.push_back(stype_word(0, 10, 32));
    prog.push_back(rtype_word(7'h00, f3_sll, 16, 1, 1));
    prog.push_back(rtype_word(7'h00, f3_sr, 17, 15, 1));          // srl
    prog.push_back(rtype_word(7'h20, f3_sr, 18, 6, 1));           // sra
    prog.push_back(stype_word(16, 10, 36));
    prog.push_back(stype_word(17, 10, 40));
    prog.push_back(stype_word(18, 10, 44));
    prog.push_back(itype_word(op_load, mem_word, 19, 10, 0));     // reads back 17
    prog.push_back(itype_word(op_imm, f3_add, 20, 19, 3));        // load-use
    prog.push_back(stype_word(20, 10, 48));
    prog.push_back(itype_word(op_load, mem_word, 21, 10, 32'h80)); // unwritten word
    prog.push_back(rtype_word(7'h00, f3_add, 22, 21, 1));
    prog.push_back(stype_word(22, 10, 52));
    prog.push_back(itype_word(op_load, mem_word, 23, 10, 4));
    prog.push_back(stype_word(23, 10, 56));                       // load-use on store data
  endtask

  task automatic load_expected();
    expect_store(32'h100, 32'd17);
    expect_store(32'h104, 32'd12);
    expect_store(32'h108, 32'hffff_ffeb);   // -81 >>> 2
    expect_store(32'h10c, 32'h0000_000f);
    expect_store(32'h110, 32'd1);
    expect_store(32'h114, 32'd0);
    expect_store(32'h118, 32'h0000_0041);
    expect_store(32'h11c, 32'h1234_5000);
    expect_store(32'h120, 32'd0);           // x0 still zero
    expect_store(32'h124, 32'h0000_00a0);
    expect_store(32'h128, 32'h0091_a280);
    expect_store(32'h12c, 32'hffff_fffd);
    expect_store(32'h130, 32'd20);
    expect_store(32'h134, fill_word(32'h180) + 32'd5);
    expect_store(32'h138, 32'd12);
  endtask

  // inputs change just after the edge and memories answer by random choice
  always @(posedge clk) begin
    cycle_count++;
    #DRIVE_DELAY;
    rst = (cycle_count < RESET_CYCLES);
    if (rst) begin
      instr_mem_resp = 1'b0;
      data_mem_resp  = 1'b0;
    end else begin
      rnd = xorshift(rnd);
      instr_mem_resp = (rnd[1:0] != 2'b00);  // about 3 cycles in 4
      data_mem_resp  = (rnd[9:8] != 2'b00);
    end
    // read data only means something with a request and its response
    instr_mem_rdata = (instr_read && instr_mem_resp) ? instr_at(instr_mem_address) : 'x;
    data_mem_rdata  = (data_read && data_mem_resp) ? data_at(data_mem_address) : 'x;
  end

  // mid-cycle sampling of requests
  always @(negedge clk) begin
    store_t s;
    if (cycle_count > 0 && rst) begin
      if (instr_read || data_read || data_write) fail_run("memory request raised during reset");
    end else if (cycle_count > 0) begin
      if (instr_read) begin
        if (!fetch_started) check_word("instr_mem_address", instr_mem_address, `RV_RESET_PC);
        else if (instr_mem_address != last_fetch && instr_mem_address != last_fetch + 32'd4)
          fail_run($sformatf("** Error: instr_mem_address = 0x%h, expected 0x%h or 0x%h",
                             instr_mem_address, last_fetch, last_fetch + 32'd4));
        fetch_started = 1'b1;
        last_fetch    = instr_mem_address;
      end
      if (data_read) check_mask("data_mbe", data_mbe, 4'b1111);  // loads are whole words
      // store retires only when nothing freezes the pipeline
      if (data_write && data_mem_resp && instr_mem_resp) begin
        s.addr = data_mem_address;
        s.data = data_mem_wdata;
        s.mask = data_mbe;
        seen.push_back(s);
        dmem[data_mem_address] = data_mem_wdata;
      end
    end
  end

  initial begin
    int     waited;
    store_t got;
    clk             = 1'b0;
    rst             = 1'b1;
    instr_mem_resp  = 1'b0;
    data_mem_resp   = 1'b0;
    instr_mem_rdata = `RV_NOP;
    data_mem_rdata  = '0;
    rnd             = 32'd4;  // seed
    cycle_count     = 0;
    fetch_started   = 1'b0;
    last_fetch      = '0;
    load_program();
    load_expected();

    waited = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > RESET_CYCLES + 4) fail_run("reset was never released");
    end
    // nothing requested yet in the first cycle out of reset
    if (instr_read || data_read || data_write) fail_run("memory request raised right after reset");

    foreach (expected[i]) begin
      waited = 0;
      while (seen.size() == 0) begin
        @(posedge clk);
        waited++;
        if (waited > STORE_TIMEOUT) fail_run($sformatf("timed out waiting for store %0d", i));
      end
      got = seen.pop_front();
      check_word("data_mem_address", got.addr, expected[i].addr);
      check_word("data_mem_wdata", got.data, expected[i].data);
      check_mask("data_mbe", got.mask, expected[i].mask);
    end

    repeat (DRAIN_CYCLES) @(posedge clk);  // only nops left in flight
    if (seen.size() != 0) begin
      fail_run("store seen after the last expected one");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+common
common/rv32i_isa_pkg.sv
common/pipe_pkg.sv
source/fetch_stage.sv
decode/instr_decoder.sv
decode/regfile.sv
execute/hazard_unit.sv
execute/execute_stage.sv
source/memory_stage.sv
source/cpu_pipeline.sv
dv/tb_cpu_pipeline.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_cpu_pipeline
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_TEXT = Testbench passed

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) common/rv32i_settings.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
